/* common/game_pkg.sv */
`default_nettype none

package game_pkg;

  // playfield in pixels
  localparam int SCREEN_W = 1024;
  localparam int SCREEN_H = 768;

  // duck sprite box
  localparam int DUCK_W = 64;
  localparam int DUCK_H = 48;

  // motion per frame
  localparam int H_SPEED = 10;
  localparam int V_SPEED = 4;

  // rounds loaded at game start, two BCD digits
  localparam logic [7:0] AMMO_START = 8'h10;

  localparam int COORD_W = 10; // enough for 0..1023

  // right-most legal column for the box's left edge
  localparam int DUCK_MAX_X = SCREEN_W - DUCK_W;

  // duck enters with its box resting on the bottom edge
  localparam int DUCK_START_Y = SCREEN_H - DUCK_H;

endpackage

`default_nettype wire

/* common/disp_pkg.sv */
`default_nettype none

package disp_pkg;

  localparam int DIGIT_W = 4; // one BCD digit
  localparam int BCD_MAX = 9;

  // each digit stays lit for 2**REFRESH_W cycles
  // kept small so a full sweep is short in simulation, widen on a board
  localparam int REFRESH_W = 4;

  // segments and anodes are active low
  localparam logic [6:0] SEG_BLANK = 7'b1111111;
  localparam logic [3:0] AN_OFF    = 4'b1111;

endpackage

`default_nettype wire

/* common/itf_duck.sv */
`default_nettype none

interface itf_duck import game_pkg::*; ();

  logic [COORD_W-1:0] duck_x;    // left edge of the box
  logic [COORD_W-1:0] duck_y;    // top edge of the box
  logic               duck_show; // duck is on screen and alive
  logic               duck_hit;  // one-cycle pulse when shot down

  modport ctl (
    output duck_x, duck_y, duck_show, duck_hit
  );

  modport user (
    input duck_x, duck_y, duck_show
  );

endinterface

`default_nettype wire

/* hw/ctl_duck.sv */
`default_nettype none

module ctl_duck import game_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               new_frame,
  input  logic               game_start,
  input  logic               hit,
  input  logic [COORD_W-1:0] start_x,
  input  logic               start_right,
  itf_duck.ctl               duck
);

  logic             direction; // 1 while flying right
  logic [COORD_W:0] x_right;   // spare bit for the wall test

  assign x_right = {1'b0, duck.duck_x} + (COORD_W+1)'(H_SPEED);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duck.duck_x    <= '0;
      duck.duck_y    <= '0;
      duck.duck_show <= 1'b0;
      duck.duck_hit  <= 1'b0;
      direction      <= 1'b0;
    end else begin
      duck.duck_hit <= 1'b0;
      if (game_start) begin
        duck.duck_x    <= start_x;
        duck.duck_y    <= COORD_W'(DUCK_START_Y);
        duck.duck_show <= 1'b1;
        direction      <= start_right;
      end else if (hit) begin
        duck.duck_hit  <= 1'b1; // falls out of the sky
        duck.duck_show <= 1'b0;
      end else if (new_frame && duck.duck_show) begin
        // horizontal step with bounce
        if (direction) begin
          if (x_right > DUCK_MAX_X) begin
            duck.duck_x <= COORD_W'(DUCK_MAX_X);
            direction   <= 1'b0;
          end else begin
            duck.duck_x <= x_right[COORD_W-1:0];
          end
        end else begin
          if (duck.duck_x < COORD_W'(H_SPEED)) begin
            duck.duck_x <= '0; // left wall
            direction   <= 1'b1;
          end else begin
            duck.duck_x <= duck.duck_x - COORD_W'(H_SPEED);
          end
        end

        // climb, or get away over the top
        if (duck.duck_y < COORD_W'(V_SPEED))
          duck.duck_show <= 1'b0;
        else
          duck.duck_y <= duck.duck_y - COORD_W'(V_SPEED);
      end
    end
  end

  a_x_in_field: assert property (
    @(posedge clk) disable iff (!rst_n)
    duck.duck_x <= COORD_W'(DUCK_MAX_X)
  ) else $error("duck_x %0d past right wall", duck.duck_x);

endmodule

`default_nettype wire

/* hw/ctl_trigger.sv */
`default_nettype none

module ctl_trigger import game_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               shot,
  input  logic [COORD_W-1:0] aim_x,
  input  logic [COORD_W-1:0] aim_y,
  input  logic               no_ammo,
  itf_duck.user              duck,
  output logic               hit,
  output logic               miss,
  output logic               shot_fired
);

  logic [COORD_W:0] box_right;  // first column past the box
  logic [COORD_W:0] box_bottom; // first row below the box
  logic             in_box;

  assign box_right  = {1'b0, duck.duck_x} + (COORD_W+1)'(DUCK_W);
  assign box_bottom = {1'b0, duck.duck_y} + (COORD_W+1)'(DUCK_H);

  assign in_box = duck.duck_show &&
                  (aim_x >= duck.duck_x) && ({1'b0, aim_x} < box_right) &&
                  (aim_y >= duck.duck_y) && ({1'b0, aim_y} < box_bottom);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit        <= 1'b0;
      miss       <= 1'b0;
      shot_fired <= 1'b0;
    end else begin
      // empty gun just clicks
      if (shot && !no_ammo) begin
        hit        <= in_box;
        miss       <= !in_box;
        shot_fired <= 1'b1;
      end else begin
        hit        <= 1'b0;
        miss       <= 1'b0;
        shot_fired <= 1'b0;
      end
    end
  end

  // trigger arrives as a clean one-cycle strobe
  a_shot_strobe: assert property (
    @(posedge clk) disable iff (!rst_n)
    shot |=> !shot
  ) else $error("shot held high for more than one cycle");

endmodule

`default_nettype wire

/* hw/ctl_tally.sv */
`default_nettype none

module ctl_tally import game_pkg::*, disp_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               game_start,
  input  logic               hit,
  input  logic               shot_fired,
  output logic               no_ammo,
  output logic [DIGIT_W-1:0] digit_0, // ammo ones
  output logic [DIGIT_W-1:0] digit_1, // ammo tens
  output logic [DIGIT_W-1:0] digit_2, // score ones
  output logic [DIGIT_W-1:0] digit_3  // score tens
);

  logic score_full;

  assign score_full = (digit_3 == DIGIT_W'(BCD_MAX)) && (digit_2 == DIGIT_W'(BCD_MAX));
  assign no_ammo    = (digit_1 == '0) && (digit_0 == '0);

  // ammunition, counts down
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digit_0 <= '0;
      digit_1 <= '0;
    end else if (game_start) begin
      digit_1 <= AMMO_START[2*DIGIT_W-1:DIGIT_W];
      digit_0 <= AMMO_START[DIGIT_W-1:0];
    end else if (shot_fired && !no_ammo) begin
      if (digit_0 == '0) begin
        digit_0 <= DIGIT_W'(BCD_MAX); // borrow from tens
        digit_1 <= digit_1 - 1'b1;
      end else begin
        digit_0 <= digit_0 - 1'b1;
      end
    end
  end

  // score, counts up and sticks at 99
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digit_2 <= '0;
      digit_3 <= '0;
    end else if (game_start) begin
      digit_2 <= '0;
      digit_3 <= '0;
    end else if (hit && !score_full) begin
      if (digit_2 == DIGIT_W'(BCD_MAX)) begin
        digit_2 <= '0;
        digit_3 <= digit_3 + 1'b1;
      end else begin
        digit_2 <= digit_2 + 1'b1;
      end
    end
  end

  a_digits_bcd: assert property (
    @(posedge clk) disable iff (!rst_n)
    (digit_0 <= BCD_MAX) && (digit_1 <= BCD_MAX) &&
    (digit_2 <= BCD_MAX) && (digit_3 <= BCD_MAX)
  ) else $error("tally digit left BCD range");

endmodule

`default_nettype wire

/* hw/disp_hex_mux.sv */
`default_nettype none

module disp_hex_mux import disp_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [DIGIT_W-1:0] digit_0,
  input  logic [DIGIT_W-1:0] digit_1,
  input  logic [DIGIT_W-1:0] digit_2,
  input  logic [DIGIT_W-1:0] digit_3,
  output logic [3:0]         an,
  output logic [6:0]         seg, // gfedcba
  output logic               dp
);

  logic [REFRESH_W+1:0] refresh_cnt;
  logic [1:0]           sel;
  logic [DIGIT_W-1:0]   digit_sel;
  logic [6:0]           seg_next;

  assign sel = refresh_cnt[REFRESH_W+1:REFRESH_W]; // top two bits pick the digit

  always_comb begin
    case (sel)
      2'd0:    digit_sel = digit_0;
      2'd1:    digit_sel = digit_1;
      2'd2:    digit_sel = digit_2;
      default: digit_sel = digit_3;
    endcase
  end

  always_comb begin
    case (digit_sel)
      4'd0:    seg_next = 7'b1000000;
      4'd1:    seg_next = 7'b1111001;
      4'd2:    seg_next = 7'b0100100;
      4'd3:    seg_next = 7'b0110000;
      4'd4:    seg_next = 7'b0011001;
      4'd5:    seg_next = 7'b0010010;
      4'd6:    seg_next = 7'b0000010;
      4'd7:    seg_next = 7'b1111000;
      4'd8:    seg_next = 7'b0000000;
      4'd9:    seg_next = 7'b0010000;
      default: seg_next = SEG_BLANK; // not a BCD value
    endcase
  end

  // outputs registered so the pins never glitch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refresh_cnt <= '0;
      an          <= AN_OFF;
      seg         <= SEG_BLANK;
      dp          <= 1'b1;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;
      an          <= ~(4'b0001 << sel);
      seg         <= seg_next;
      dp          <= (sel != 2'd2); // dot between score and ammo
    end
  end

endmodule

`default_nettype wire

/* hw/duck_hunt_ctl.sv */
`default_nettype none

module duck_hunt_ctl import game_pkg::*, disp_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               new_frame,
  input  logic               game_start,
  input  logic               shot,        // clean one-cycle trigger
  input  logic [COORD_W-1:0] aim_x,
  input  logic [COORD_W-1:0] aim_y,
  input  logic [COORD_W-1:0] start_x,
  input  logic               start_right,
  output logic [COORD_W-1:0] duck_x,
  output logic [COORD_W-1:0] duck_y,
  output logic               duck_show,
  output logic               duck_hit,
  output logic               hit,
  output logic               miss,
  output logic               no_ammo,
  output logic [3:0]         an,
  output logic [6:0]         seg,
  output logic               dp
);

  itf_duck duck_bus ();

  logic               shot_fired;
  logic [DIGIT_W-1:0] digit_0, digit_1, digit_2, digit_3;

  assign duck_x    = duck_bus.duck_x;
  assign duck_y    = duck_bus.duck_y;
  assign duck_show = duck_bus.duck_show;
  assign duck_hit  = duck_bus.duck_hit;

  ctl_duck u_ctl_duck (
    .clk,
    .rst_n,
    .new_frame,
    .game_start,
    .hit,
    .start_x,
    .start_right,
    .duck (duck_bus.ctl)
  );

  ctl_trigger u_ctl_trigger (
    .clk,
    .rst_n,
    .shot,
    .aim_x,
    .aim_y,
    .no_ammo,
    .duck (duck_bus.user),
    .hit,
    .miss,
    .shot_fired
  );

  ctl_tally u_ctl_tally (
    .clk,
    .rst_n,
    .game_start,
    .hit,
    .shot_fired,
    .no_ammo,
    .digit_0,
    .digit_1,
    .digit_2,
    .digit_3
  );

  disp_hex_mux u_disp_hex_mux (
    .clk,
    .rst_n,
    .digit_0,
    .digit_1,
    .digit_2,
    .digit_3,
    .an,
    .seg,
    .dp
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD/2) clk = ~clk; // free-running, 50% duty

endmodule

`default_nettype wire

/* testbench/tb_duck_hunt_ctl.sv */
`default_nettype none

module tb_duck_hunt_ctl import game_pkg::*; ();

  logic               clk;
  logic               rst_n;
  logic               new_frame;
  logic               game_start;
  logic               shot;
  logic               start_right;
  logic [COORD_W-1:0] aim_x;
  logic [COORD_W-1:0] aim_y;
  logic [COORD_W-1:0] start_x;
  logic [COORD_W-1:0] duck_x;
  logic [COORD_W-1:0] duck_y;
  logic               duck_show;
  logic               duck_hit;
  logic               hit;
  logic               miss;
  logic               no_ammo;
  logic [3:0]         an;
  logic [6:0]         seg;
  logic               dp;

  int errors      = 0;
  int checks      = 0;
  int cycles      = 0;
  int cycle_limit = 100000; // replaced once the vectors are counted
  int frame_total = 0;
  int vec_idx     = 0;

  // parsed vector file, one entry per command
  logic [8*12-1:0] cmd_q[$];
  int              a_q[$];
  int              b_q[$];
  int              c_q[$];

  tb_clock_gen #(.PERIOD(4)) clock_gen_inst (.clk);

  duck_hunt_ctl duck_hunt_ctl_inst (
    .clk, .rst_n, .new_frame, .game_start, .shot, .aim_x, .aim_y,
    .start_x, .start_right, .duck_x, .duck_y, .duck_show, .duck_hit,
    .hit, .miss, .no_ammo, .an, .seg, .dp
  );

  // step to just after the next rising edge
  task automatic tick;
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      errors++;
      $display("[ERROR] vector %0d %s: expected %0d, actual %0d",
               vec_idx, name, expected, actual);
    end
  endtask

  // active-low gfedcba back to a digit
  function automatic int seg_to_digit(input logic [6:0] s);
    case (s)
      7'b1000000: seg_to_digit = 0;
      7'b1111001: seg_to_digit = 1;
      7'b0100100: seg_to_digit = 2;
      7'b0110000: seg_to_digit = 3;
      7'b0011001: seg_to_digit = 4;
      7'b0010010: seg_to_digit = 5;
      7'b0000010: seg_to_digit = 6;
      7'b1111000: seg_to_digit = 7;
      7'b0000000: seg_to_digit = 8;
      7'b0010000: seg_to_digit = 9;
      default:    seg_to_digit = -1;
    endcase
  endfunction

  task automatic read_digit(input int idx, output int value);
    int         waited;
    logic [3:0] want;
    waited = 0;
    want   = ~(4'b0001 << idx);
    while (an != want && waited < 80) begin
      tick;
      waited++;
    end
    checks++;
    assert (an == want) else begin
      errors++;
      $display("vector %0d: anode %0d never went active", vec_idx, idx);
    end
    if (an != want) begin
      value = -1;
    end else begin
      value = seg_to_digit(seg);
      check_value("CHECK_DISP dp", (idx == 2) ? 0 : 1, dp); // dot only on score ones
    end
  endtask

  task automatic start_game(input int sx, input int dir);
    start_x     = sx;
    start_right = dir[0];
    game_start  = 1'b1;
    tick;
    game_start  = 1'b0;
  endtask

  task automatic run_frames(input int count);
    new_frame = 1'b1; // one frame per cycle
    repeat (count) tick;
    new_frame = 1'b0;
  endtask

  // outcome 0 miss, 1 hit, 2 ignored by an empty gun
  task automatic fire_shot(input int ax, input int ay, input int outcome);
    aim_x = ax;
    aim_y = ay;
    shot  = 1'b1;
    tick;
    shot  = 1'b0;
    check_value("SHOOT hit", outcome == 1, hit);
    check_value("SHOOT miss", outcome == 0, miss);
    tick; // duck and tally react one edge later
    check_value("SHOOT duck_hit", outcome == 1, duck_hit);
    if (outcome == 1)
      check_value("SHOOT duck_show", 0, duck_show);
  endtask

  task automatic check_pos(input int x, input int y, input int show);
    check_value("CHECK_POS duck_x", x, duck_x);
    check_value("CHECK_POS duck_y", y, duck_y);
    check_value("CHECK_POS duck_show", show, duck_show);
  endtask

  task automatic check_display(input int score, input int ammo);
    int d[4];
    tick; // segments follow the digits one edge later
    for (int i = 0; i < 4; i++)
      read_digit(i, d[i]);
    check_value("CHECK_DISP score", score, d[3] * 10 + d[2]);
    check_value("CHECK_DISP ammo", ammo, d[1] * 10 + d[0]);
    check_value("CHECK_DISP no_ammo", (ammo == 0) ? 1 : 0, no_ammo);
  endtask

  task automatic run_command(input logic [8*12-1:0] cmd, input int a, input int b,
                             input int c);
    case (cmd)
      "START":      start_game(a, b);
      "FRAME":      run_frames(a);
      "SHOOT":      fire_shot(a, b, c);
      "CHECK_POS":  check_pos(a, b, c);
      "CHECK_DISP": check_display(a, b);
      default: begin
        errors++;
        $display("vector %0d: unknown command", vec_idx);
      end
    endcase
  endtask

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("errors: %0d, checks: %0d", errors, checks);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int              fd;
    int              n;
    int              a;
    int              b;
    int              c;
    logic [8*12-1:0] word;
    logic [8*200-1:0] rest;

    rst_n       = 1'b0;
    new_frame   = 1'b0;
    game_start  = 1'b0;
    shot        = 1'b0;
    start_right = 1'b0;
    aim_x       = '0;
    aim_y       = '0;
    start_x     = '0;

    fd = $fopen("testbench/duck_hunt_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open testbench/duck_hunt_vectors.txt");
    end else begin
      while ($fscanf(fd, "%s", word) == 1) begin
        a = 0;
        b = 0;
        c = 0;
        if (word == "#") begin
          n = $fgets(rest, fd); // rest of a comment line
        end else begin
          // n counts the fields still missing
          case (word)
            "FRAME":      n = 1 - $fscanf(fd, "%d", a);
            "START",
            "CHECK_DISP": n = 2 - $fscanf(fd, "%d %d", a, b);
            default:      n = 3 - $fscanf(fd, "%d %d %d", a, b, c);
          endcase
          if (n != 0) begin
            errors++;
            $display("vector %0d: line has %0d fields missing", cmd_q.size(), n);
          end
          if (word == "FRAME")
            frame_total += a;
          cmd_q.push_back(word);
          a_q.push_back(a);
          b_q.push_back(b);
          c_q.push_back(c);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 40 * cmd_q.size() + 16 * frame_total;

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < cmd_q.size(); i++) begin
      vec_idx = i;
      run_command(cmd_q[i], a_q[i], b_q[i], c_q[i]);
    end

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* duck_hunt_ctl.f */
common/game_pkg.sv
common/disp_pkg.sv
common/itf_duck.sv
hw/ctl_duck.sv
hw/ctl_trigger.sv
hw/ctl_tally.sv
hw/disp_hex_mux.sv
hw/duck_hunt_ctl.sv
testbench/tb_clock_gen.sv
testbench/tb_duck_hunt_ctl.sv

/* testbench/duck_hunt_vectors.txt */
# START x dir | FRAME n | SHOOT aim_x aim_y expect (0 miss, 1 hit, 2 none)
# CHECK_POS x y show | CHECK_DISP score ammo
# after reset
CHECK_POS 0 0 0
CHECK_DISP 0 0
SHOOT 0 0 2
# flight from the bottom edge
START 100 1
CHECK_POS 100 720 1
FRAME 5
CHECK_POS 150 700 1
# miss, box edge, then hit
SHOOT 10 10 0
SHOOT 214 720 0
SHOOT 150 747 1
CHECK_POS 150 700 0
CHECK_DISP 1 7
# right wall bounce
START 950 1
FRAME 2
CHECK_POS 960 712 1
FRAME 1
CHECK_POS 950 708 1
# left wall bounce
START 15 0
FRAME 3
CHECK_POS 10 708 1
# empty the gun
SHOOT 20 720 1
SHOOT 20 720 0
SHOOT 20 720 0
SHOOT 20 720 0
SHOOT 20 720 0
CHECK_DISP 1 5
SHOOT 20 720 0
SHOOT 20 720 0
SHOOT 20 720 0
SHOOT 20 720 0
SHOOT 20 720 0
CHECK_DISP 1 0
SHOOT 20 720 2
CHECK_DISP 1 0
# escape over the top
START 500 1
FRAME 180
CHECK_POS 360 0 1
FRAME 1
CHECK_POS 370 0 0
